// ==== sim/ecc_tb_tasks.svh ====
// ECC testbench tasks
`ifndef ECC_TB_TASKS_SVH
`define ECC_TB_TASKS_SVH

// ------------------------------
// Failure handling and models
// ------------------------------
task automatic stop_run();
    $display("TESTS FAILED");
    $fatal(1, "stopping at first failure");
endtask

task automatic check_value(string name, longint unsigned got, longint unsigned exp);
    assert (got == exp) else begin
        $display("[ERROR] t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        stop_run();
    end
endtask

function automatic ecc_arith_pkg::reg_t modulus_of(logic mod_q);
    return mod_q ? ecc_arith_pkg::Q_ORDER : ecc_arith_pkg::P_PRIME;
endfunction

// Uniform operand in [0, m)
function automatic ecc_arith_pkg::reg_t rand_below(ecc_arith_pkg::reg_t m);
    return ecc_arith_pkg::reg_t'($urandom % m);
endfunction

// Square and multiply with exponents up to 2^16
function automatic ecc_arith_pkg::reg_t mod_pow(ecc_arith_pkg::reg_t base, int unsigned e,
                                                ecc_arith_pkg::reg_t m);
    longint unsigned acc;
    longint unsigned b;
    int unsigned     k;
    acc = 1;
    b   = base;
    k   = e;
    while (k != 0) begin
        if (k[0]) begin
            acc = (acc * b) % m;
        end
        b = (b * b) % m;
        k = k >> 1;
    end
    return ecc_arith_pkg::reg_t'(acc % m);
endfunction

// ------------------------------
// Host port access
// ------------------------------
// Slot is written on the second edge after the strobe
task automatic write_slot(ecc_arith_pkg::addr_t a, ecc_arith_pkg::reg_t d);
    @(posedge clk);
    addr      <= a;
    data_in   <= d;
    wr_op_sel <= 1'b0;
    wr_en     <= 1'b1;
    @(posedge clk);
    wr_en     <= 1'b0;
    @(posedge clk);
endtask

task automatic load_key(ecc_arith_pkg::reg_t k);
    @(posedge clk);
    data_in   <= k;
    wr_op_sel <= 1'b1;
    wr_en     <= 1'b1;
    @(posedge clk);
    wr_en     <= 1'b0;
    wr_op_sel <= 1'b0;
endtask

// Sampled at the falling edge after three edges of latency
task automatic read_slot(ecc_arith_pkg::addr_t a, output ecc_arith_pkg::reg_t d);
    @(posedge clk);
    addr   <= a;
    rd_reg <= 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    d = data_out;
    @(posedge clk);
    rd_reg <= 1'b0;
endtask

// One-cycle command strobe
task automatic start_command(ecc_arith_pkg::cmd_t cmd);
    @(posedge clk);
    ecc_cmd <= cmd;
    @(posedge clk);
    ecc_cmd <= '0;
endtask

// Counts busy cycles until busy falls
task automatic wait_idle(output int n);
    n = 0;
    @(negedge clk);
    while (busy) begin
        n++;
        if (n > BUSY_LIMIT) begin
            $display("busy_o stayed high for more than %0d cycles", BUSY_LIMIT);
            stop_run();
        end
        @(negedge clk);
    end
endtask

task automatic run_command(ecc_arith_pkg::cmd_t cmd, output int n);
    start_command(cmd);
    wait_idle(n);
endtask

// ------------------------------
// Directed tests
// ------------------------------
task automatic test_memory();
    ecc_arith_pkg::reg_t got;
    ecc_arith_pkg::reg_t pat;
    for (int i = 0; i < 8; i++) begin
        pat = ecc_arith_pkg::reg_t'((i + 1) * 16'h9e37) ^ {13'h0a5c, 3'(i)};
        write_slot(ecc_arith_pkg::addr_t'(i), pat);
    end
    for (int i = 0; i < 8; i++) begin
        pat = ecc_arith_pkg::reg_t'((i + 1) * 16'h9e37) ^ {13'h0a5c, 3'(i)};
        read_slot(ecc_arith_pkg::addr_t'(i), got);
        check_value("data_o", got, pat);
    end
    // Read port quiet while rd_reg is low
    @(posedge clk);
    addr <= 3'd3;
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_value("data_o idle", data_out, 0);
endtask

task automatic test_add_sub(logic sub, logic mod_q);
    ecc_arith_pkg::reg_t m;
    ecc_arith_pkg::reg_t a;
    ecc_arith_pkg::reg_t b;
    ecc_arith_pkg::reg_t got;
    ecc_arith_pkg::reg_t exp;
    ecc_arith_pkg::cmd_t cmd;
    int                  n;
    m = modulus_of(mod_q);
    if (sub) begin
        cmd = mod_q ? ecc_arith_pkg::CMD_SUB_Q : ecc_arith_pkg::CMD_SUB_P;
    end else begin
        cmd = mod_q ? ecc_arith_pkg::CMD_ADD_Q : ecc_arith_pkg::CMD_ADD_P;
    end
    for (int i = 0; i < 8; i++) begin
        // Edge pairs first and random pairs after
        case (i)
            0: begin
                a = m - 1;
                b = m - 1;
            end
            1: begin
                a = 0;
                b = 0;
            end
            2: begin
                a = 3;
                b = m - 2;
            end
            3: begin
                a = m - 1;
                b = 1;
            end
            default: begin
                a = rand_below(m);
                b = rand_below(m);
            end
        endcase
        write_slot(ecc_arith_pkg::SLOT_OPA, a);
        write_slot(ecc_arith_pkg::SLOT_OPB, b);
        run_command(cmd, n);
        check_value("busy_o cycles", n, 5);
        if (sub) begin
            exp = ecc_arith_pkg::reg_t'((int'(a) - int'(b) + int'(m)) % int'(m));
        end else begin
            exp = ecc_arith_pkg::reg_t'((int'(a) + int'(b)) % int'(m));
        end
        read_slot(ecc_arith_pkg::SLOT_OPA, got);
        check_value("data_o slot0", got, exp);
    end
endtask

// Ladder from R0 = 1, R1 = x
task automatic exp_case(logic mod_q, ecc_arith_pkg::reg_t key, ecc_arith_pkg::reg_t x,
                        bit load);
    ecc_arith_pkg::reg_t m;
    ecc_arith_pkg::reg_t got;
    int                  n;
    m = modulus_of(mod_q);
    write_slot(ecc_arith_pkg::SLOT_R0, 16'd1);
    write_slot(ecc_arith_pkg::SLOT_R1, x);
    if (load) begin
        load_key(key);
    end
    run_command(mod_q ? ecc_arith_pkg::CMD_EXP_Q : ecc_arith_pkg::CMD_EXP_P, n);
    check_value("busy_o seen", n != 0, 1);
    read_slot(ecc_arith_pkg::SLOT_R0, got);
    check_value("data_o R0", got, mod_pow(x, key, m));
    read_slot(ecc_arith_pkg::SLOT_R1, got);
    check_value("data_o R1", got, mod_pow(x, int'(key) + 1, m));
endtask

task automatic test_exp(logic mod_q);
    ecc_arith_pkg::reg_t m;
    m = modulus_of(mod_q);
    exp_case(mod_q, 16'h0000, rand_below(m), 1'b1);
    exp_case(mod_q, 16'h0001, rand_below(m), 1'b1);
    exp_case(mod_q, 16'hffff, rand_below(m), 1'b1);
    exp_case(mod_q, ecc_arith_pkg::reg_t'($urandom), rand_below(m), 1'b1);
endtask

// Second run relies on the rotated-back scalar
task automatic test_key_restore();
    ecc_arith_pkg::reg_t key;
    key = ecc_arith_pkg::reg_t'($urandom);
    exp_case(1'b0, key, rand_below(ecc_arith_pkg::P_PRIME), 1'b1);
    exp_case(1'b0, key, rand_below(ecc_arith_pkg::P_PRIME), 1'b0);
endtask

task automatic test_cmd_while_busy();
    ecc_arith_pkg::reg_t a;
    ecc_arith_pkg::reg_t b;
    ecc_arith_pkg::reg_t x;
    ecc_arith_pkg::reg_t key;
    ecc_arith_pkg::reg_t got;
    int                  n;
    a   = rand_below(ecc_arith_pkg::P_PRIME);
    b   = rand_below(ecc_arith_pkg::P_PRIME);
    x   = rand_below(ecc_arith_pkg::P_PRIME);
    key = ecc_arith_pkg::reg_t'($urandom);
    write_slot(ecc_arith_pkg::SLOT_OPA, a);
    write_slot(ecc_arith_pkg::SLOT_OPB, b);
    write_slot(ecc_arith_pkg::SLOT_R0, 16'd1);
    write_slot(ecc_arith_pkg::SLOT_R1, x);
    load_key(key);
    start_command(ecc_arith_pkg::CMD_EXP_P);
    repeat (40) @(posedge clk);
    @(negedge clk);
    check_value("busy_o", busy, 1);
    // Strobe lands in the middle of the ladder
    start_command(ecc_arith_pkg::CMD_ADD_P);
    wait_idle(n);
    read_slot(ecc_arith_pkg::SLOT_OPA, got);
    check_value("data_o slot0", got, a);
    read_slot(ecc_arith_pkg::SLOT_OPB, got);
    check_value("data_o slot1", got, b);
    read_slot(ecc_arith_pkg::SLOT_R0, got);
    check_value("data_o R0", got, mod_pow(x, key, ecc_arith_pkg::P_PRIME));
endtask

`endif

// ==== sim/ecc_arith_unit_tb.sv ====
// ECC arithmetic unit testbench
`timescale 1ns/1ps
module ecc_arith_unit_tb;

    // Longest legal busy wait
    localparam int BUSY_LIMIT  = 2000;
    // 11 ladder runs of about 720 cycles plus host traffic and a wide margin
    localparam int CYCLE_LIMIT = 60000;

    logic                 clk;
    logic                 reset_n;
    ecc_arith_pkg::cmd_t  ecc_cmd;
    ecc_arith_pkg::addr_t addr;
    logic                 wr_op_sel;
    logic                 wr_en;
    logic                 rd_reg;
    ecc_arith_pkg::reg_t  data_in;
    ecc_arith_pkg::reg_t  data_out;
    logic                 busy;

    int cycle_cnt = 0;

    `include "ecc_tb_tasks.svh"

    // ------------------------------
    // DUT
    // ------------------------------
    ecc_arith_unit i_dut (
        .clk         (clk),
        .reset_n     (reset_n),
        .ecc_cmd_i   (ecc_cmd),
        .addr_i      (addr),
        .wr_op_sel_i (wr_op_sel),
        .wr_en_i     (wr_en),
        .rd_reg_i    (rd_reg),
        .data_i      (data_in),
        .data_o      (data_out),
        .busy_o      (busy)
    );

    // 10 ns clock
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Global cycle limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Run exceeded the limit of %0d cycles", CYCLE_LIMIT);
            stop_run();
        end
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        int unsigned seed_init;
        seed_init = $urandom(32'hfe8);
        reset_n   <= 1'b0;
        ecc_cmd   <= '0;
        addr      <= '0;
        wr_op_sel <= 1'b0;
        wr_en     <= 1'b0;
        rd_reg    <= 1'b0;
        data_in   <= '0;
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        // Outputs quiet out of reset
        check_value("busy_o", busy, 0);
        check_value("data_o", data_out, 0);

        test_memory();
        test_add_sub(1'b0, 1'b0);
        test_add_sub(1'b0, 1'b1);
        test_add_sub(1'b1, 1'b0);
        test_add_sub(1'b1, 1'b1);
        test_exp(1'b0);
        test_exp(1'b1);
        test_key_restore();
        test_cmd_while_busy();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== src/ecc_arith_pkg.sv ====
// ECC arithmetic definitions
package ecc_arith_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int REG_SIZE   = 16;
    localparam int KEY_SIZE   = 16;
    localparam int ADDR_WIDTH = 3;
    localparam int INSTR_SIZE = 12;

    typedef logic [REG_SIZE-1:0]   reg_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [INSTR_SIZE-1:0] instr_t;
    typedef logic [2:0]            cmd_t;

    // Field prime and group order
    localparam reg_t P_PRIME = 16'd65521;
    localparam reg_t Q_ORDER = 16'd65519;

    // Host commands, bit 2 picks mod q
    localparam cmd_t CMD_ADD_P = 3'b001;
    localparam cmd_t CMD_SUB_P = 3'b010;
    localparam cmd_t CMD_EXP_P = 3'b011;
    localparam cmd_t CMD_ADD_Q = 3'b101;
    localparam cmd_t CMD_SUB_Q = 3'b110;
    localparam cmd_t CMD_EXP_Q = 3'b111;

    // ------------------------------
    // Microcode word layout
    // ------------------------------
    localparam int INSTR_ADDRB_LSB = 0;
    localparam int INSTR_ADDRA_LSB = 3;
    localparam int INSTR_WEB_BIT   = 6;
    localparam int INSTR_WEA_BIT   = 7;
    localparam int INSTR_SUB_BIT   = 8;
    localparam int INSTR_ADD_BIT   = 9;
    localparam int INSTR_MULT_BIT  = 10;
    localparam int INSTR_MODQ_BIT  = 11;

    // ROM word indices, two-word ladder programs first
    localparam logic [2:0] UC_D0_A = 3'd0;
    localparam logic [2:0] UC_D0_B = 3'd1;
    localparam logic [2:0] UC_D1_A = 3'd2;
    localparam logic [2:0] UC_D1_B = 3'd3;
    localparam logic [2:0] UC_ADD  = 3'd4;
    localparam logic [2:0] UC_SUB  = 3'd5;

    // Operand slots
    localparam addr_t SLOT_OPA = 3'd0;
    localparam addr_t SLOT_OPB = 3'd1;
    localparam addr_t SLOT_R0  = 3'd4;
    localparam addr_t SLOT_R1  = 3'd5;

    typedef enum logic [2:0] {
        IDLE,
        DIGIT,
        ISSUE,
        READ,
        EXEC,
        WRITE,
        NEXT
    } pm_state_e;

endpackage

// ==== src/ecc_arith_unit.sv ====
// ECC arithmetic unit top
`timescale 1ns/1ps
module ecc_arith_unit (
    input  logic                 clk,
    input  logic                 reset_n,
    // Host port
    input  ecc_arith_pkg::cmd_t  ecc_cmd_i,
    input  ecc_arith_pkg::addr_t addr_i,
    input  logic                 wr_op_sel_i,
    input  logic                 wr_en_i,
    input  logic                 rd_reg_i,
    input  ecc_arith_pkg::reg_t  data_i,
    output ecc_arith_pkg::reg_t  data_o,
    output logic                 busy_o
);

    ecc_arith_pkg::instr_t instr;
    ecc_arith_pkg::reg_t   opa;
    ecc_arith_pkg::reg_t   opb;
    ecc_arith_pkg::reg_t   add_res;
    ecc_arith_pkg::reg_t   mult_res;
    logic                  mult_done;
    logic                  mod_q;
    logic                  req_digit;
    logic                  busy;

    // Host side registers
    ecc_arith_pkg::addr_t                reg_addr_r;
    ecc_arith_pkg::reg_t                 reg_dinb_r;
    logic                                reg_web_r;
    logic [ecc_arith_pkg::KEY_SIZE-1:0]  secret_key;

    // Port B after the busy mux
    ecc_arith_pkg::addr_t addrb_mux;
    ecc_arith_pkg::reg_t  dinb_mux;
    logic                 web_mux;

    // ------------------------------
    // Sequencer
    // ------------------------------
    ecc_pm_ctrl u_pm_ctrl (
        .clk         (clk),
        .reset_n     (reset_n),
        .ecc_cmd_i   (ecc_cmd_i),
        .digit_i     (secret_key[ecc_arith_pkg::KEY_SIZE-1]),
        .mult_done_i (mult_done),
        .instr_o     (instr),
        .mod_q_o     (mod_q),
        .req_digit_o (req_digit),
        .busy_o      (busy)
    );

    // ------------------------------
    // Operand memory
    // ------------------------------
    ecc_ram_tdp_file #(
        .DATA_WIDTH (ecc_arith_pkg::REG_SIZE),
        .ADDR_WIDTH (ecc_arith_pkg::ADDR_WIDTH)
    ) u_ram (
        .clk_i   (clk),
        .reset_n (reset_n),
        .wea_i   (instr[ecc_arith_pkg::INSTR_WEA_BIT]),
        .addra_i (instr[ecc_arith_pkg::INSTR_ADDRA_LSB +: ecc_arith_pkg::ADDR_WIDTH]),
        .dina_i  (add_res),
        .douta_o (opa),
        .web_i   (web_mux),
        .addrb_i (addrb_mux),
        .dinb_i  (dinb_mux),
        .doutb_o (opb)
    );

    // Sequencer owns port B while busy
    assign addrb_mux = busy ? instr[ecc_arith_pkg::INSTR_ADDRB_LSB +: ecc_arith_pkg::ADDR_WIDTH]
                            : reg_addr_r;
    assign web_mux   = busy ? instr[ecc_arith_pkg::INSTR_WEB_BIT] : reg_web_r;
    assign dinb_mux  = busy ? mult_res : reg_dinb_r;

    // ------------------------------
    // Field arithmetic
    // ------------------------------
    ecc_fau u_fau (
        .clk         (clk),
        .reset_n     (reset_n),
        .add_en_i    (instr[ecc_arith_pkg::INSTR_ADD_BIT]),
        .sub_i       (instr[ecc_arith_pkg::INSTR_SUB_BIT]),
        .mult_en_i   (instr[ecc_arith_pkg::INSTR_MULT_BIT]),
        .mod_q_i     (mod_q),
        .opa_i       (opa),
        .opb_i       (opb),
        .add_res_o   (add_res),
        .mult_res_o  (mult_res),
        .mult_done_o (mult_done)
    );

    // Write strobe and read-back
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            reg_web_r <= 1'b0;
            data_o    <= '0;
        end else begin
            reg_web_r <= wr_en_i && !wr_op_sel_i;
            data_o    <= rd_reg_i ? opb : '0;
        end
    end

    // Host address, write data and the scalar
    always_ff @(posedge clk) begin
        reg_addr_r <= addr_i;
        if (wr_en_i && !wr_op_sel_i) begin
            reg_dinb_r <= data_i;
        end
        if (wr_en_i && wr_op_sel_i) begin
            secret_key <= data_i;
        end else if (req_digit) begin
            // Rotate left, MSB goes out first
            secret_key <= {secret_key[ecc_arith_pkg::KEY_SIZE-2:0],
                           secret_key[ecc_arith_pkg::KEY_SIZE-1]};
        end
    end

    assign busy_o = busy;

endmodule

// ==== src/ecc_fau.sv ====
// Field arithmetic unit
`timescale 1ns/1ps
module ecc_fau (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                add_en_i,
    input  logic                sub_i,
    input  logic                mult_en_i,
    input  logic                mod_q_i,
    input  ecc_arith_pkg::reg_t opa_i,
    input  ecc_arith_pkg::reg_t opb_i,
    output ecc_arith_pkg::reg_t add_res_o,
    output ecc_arith_pkg::reg_t mult_res_o,
    output logic                mult_done_o
);

    ecc_arith_pkg::reg_t              modulus;
    logic [ecc_arith_pkg::REG_SIZE:0] sum;
    logic [ecc_arith_pkg::REG_SIZE:0] diff;
    logic [ecc_arith_pkg::REG_SIZE:0] res_nxt;

    // Modulus select
    assign modulus = mod_q_i ? ecc_arith_pkg::Q_ORDER : ecc_arith_pkg::P_PRIME;

    // ------------------------------
    // Modular add/sub
    // ------------------------------
    always_comb begin
        sum  = {1'b0, opa_i} + {1'b0, opb_i};
        diff = {1'b0, opa_i} - {1'b0, opb_i};
        if (sub_i) begin
            // Borrow out means a < b, add m back
            res_nxt = diff[ecc_arith_pkg::REG_SIZE] ? diff + {1'b0, modulus} : diff;
        end else begin
            res_nxt = (sum >= {1'b0, modulus}) ? sum - {1'b0, modulus} : sum;
        end
    end

    always_ff @(posedge clk) begin
        if (add_en_i) begin
            add_res_o <= res_nxt[ecc_arith_pkg::REG_SIZE-1:0];
        end
    end

    // Multiplier
    ecc_mod_mult u_mod_mult (
        .clk       (clk),
        .reset_n   (reset_n),
        .start_i   (mult_en_i),
        .opa_i     (opa_i),
        .opb_i     (opb_i),
        .modulus_i (modulus),
        .res_o     (mult_res_o),
        .done_o    (mult_done_o)
    );

endmodule

// ==== src/ecc_mod_mult.sv ====
// Interleaved modular multiplier
`timescale 1ns/1ps
module ecc_mod_mult (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                start_i,
    input  ecc_arith_pkg::reg_t opa_i,
    input  ecc_arith_pkg::reg_t opb_i,
    input  ecc_arith_pkg::reg_t modulus_i,
    output ecc_arith_pkg::reg_t res_o,
    output logic                done_o
);

    ecc_arith_pkg::reg_t opa_sh;
    ecc_arith_pkg::reg_t opb_r;
    ecc_arith_pkg::reg_t mod_r;
    ecc_arith_pkg::reg_t acc;

    // One extra bit for the carry of double and add
    logic [ecc_arith_pkg::REG_SIZE:0] dbl;
    logic [ecc_arith_pkg::REG_SIZE:0] dbl_red;
    logic [ecc_arith_pkg::REG_SIZE:0] sum;
    logic [ecc_arith_pkg::REG_SIZE:0] sum_red;

    logic [$clog2(ecc_arith_pkg::REG_SIZE)-1:0] step_cnt;
    logic                                       running;

    // ------------------------------
    // One step of the scan
    // ------------------------------
    always_comb begin
        // Double, acc below m so one subtraction is enough
        dbl     = {acc, 1'b0};
        dbl_red = (dbl >= {1'b0, mod_r}) ? dbl - {1'b0, mod_r} : dbl;
        // Add B when the current A bit is set
        sum     = dbl_red + (opa_sh[ecc_arith_pkg::REG_SIZE-1] ? {1'b0, opb_r} : '0);
        sum_red = (sum >= {1'b0, mod_r}) ? sum - {1'b0, mod_r} : sum;
    end

    // Step counter and done pulse
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            running  <= 1'b0;
            step_cnt <= '0;
            done_o   <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                running  <= 1'b1;
                step_cnt <= $bits(step_cnt)'(ecc_arith_pkg::REG_SIZE - 1);
            end else if (running) begin
                if (step_cnt == '0) begin
                    running <= 1'b0;
                    done_o  <= 1'b1;
                end else begin
                    step_cnt <= step_cnt - 1'b1;
                end
            end
        end
    end

    // Operands latched at start, A scanned MSB first
    always_ff @(posedge clk) begin
        if (start_i) begin
            opa_sh <= opa_i;
            opb_r  <= opb_i;
            mod_r  <= modulus_i;
            acc    <= '0;
        end else if (running) begin
            opa_sh <= {opa_sh[ecc_arith_pkg::REG_SIZE-2:0], 1'b0};
            acc    <= sum_red[ecc_arith_pkg::REG_SIZE-1:0];
        end
    end

    // Accumulator holds the product after the last step
    assign res_o = acc;

endmodule

// ==== src/ecc_pm_ctrl.sv ====
// Microcode sequencer
`timescale 1ns/1ps
module ecc_pm_ctrl (
    input  logic                  clk,
    input  logic                  reset_n,
    input  ecc_arith_pkg::cmd_t   ecc_cmd_i,
    input  logic                  digit_i,
    input  logic                  mult_done_i,
    output ecc_arith_pkg::instr_t instr_o,
    output logic                  mod_q_o,
    output logic                  req_digit_o,
    output logic                  busy_o
);

    ecc_arith_pkg::pm_state_e                   state;
    ecc_arith_pkg::instr_t                      rom_word;
    logic [2:0]                                 uc_idx;
    logic [$clog2(ecc_arith_pkg::KEY_SIZE)-1:0] digit_cnt;
    logic                                       mod_q_r;

    // Multiply word, product written back at the B slot
    function automatic ecc_arith_pkg::instr_t uc_mult(ecc_arith_pkg::addr_t a,
                                                      ecc_arith_pkg::addr_t b);
        ecc_arith_pkg::instr_t w;
        w = '0;
        w[ecc_arith_pkg::INSTR_ADDRA_LSB +: ecc_arith_pkg::ADDR_WIDTH] = a;
        w[ecc_arith_pkg::INSTR_ADDRB_LSB +: ecc_arith_pkg::ADDR_WIDTH] = b;
        w[ecc_arith_pkg::INSTR_MULT_BIT] = 1'b1;
        w[ecc_arith_pkg::INSTR_WEB_BIT]  = 1'b1;
        return w;
    endfunction

    // Add or sub word over slot0 and slot1, result to slot0
    function automatic ecc_arith_pkg::instr_t uc_add(logic sub);
        ecc_arith_pkg::instr_t w;
        w = '0;
        w[ecc_arith_pkg::INSTR_ADDRA_LSB +: ecc_arith_pkg::ADDR_WIDTH] = ecc_arith_pkg::SLOT_OPA;
        w[ecc_arith_pkg::INSTR_ADDRB_LSB +: ecc_arith_pkg::ADDR_WIDTH] = ecc_arith_pkg::SLOT_OPB;
        w[ecc_arith_pkg::INSTR_ADD_BIT] = 1'b1;
        w[ecc_arith_pkg::INSTR_SUB_BIT] = sub;
        w[ecc_arith_pkg::INSTR_WEA_BIT] = 1'b1;
        return w;
    endfunction

    // ------------------------------
    // Microcode ROM
    // ------------------------------
    always_comb begin
        case (uc_idx)
            // Digit 0: R1 = R0*R1, then R0 = R0*R0
            ecc_arith_pkg::UC_D0_A: rom_word = uc_mult(ecc_arith_pkg::SLOT_R0, ecc_arith_pkg::SLOT_R1);
            ecc_arith_pkg::UC_D0_B: rom_word = uc_mult(ecc_arith_pkg::SLOT_R0, ecc_arith_pkg::SLOT_R0);
            // Digit 1: R0 = R1*R0, then R1 = R1*R1
            ecc_arith_pkg::UC_D1_A: rom_word = uc_mult(ecc_arith_pkg::SLOT_R1, ecc_arith_pkg::SLOT_R0);
            ecc_arith_pkg::UC_D1_B: rom_word = uc_mult(ecc_arith_pkg::SLOT_R1, ecc_arith_pkg::SLOT_R1);
            ecc_arith_pkg::UC_ADD:  rom_word = uc_add(1'b0);
            ecc_arith_pkg::UC_SUB:  rom_word = uc_add(1'b1);
            default:                rom_word = '0;
        endcase
    end

    // ------------------------------
    // Sequencer FSM
    // ------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= ecc_arith_pkg::IDLE;
            uc_idx    <= '0;
            digit_cnt <= '0;
            mod_q_r   <= 1'b0;
        end else begin
            case (state)
                ecc_arith_pkg::IDLE: begin
                    digit_cnt <= '0;
                    case (ecc_cmd_i)
                        ecc_arith_pkg::CMD_ADD_P, ecc_arith_pkg::CMD_ADD_Q: begin
                            uc_idx  <= ecc_arith_pkg::UC_ADD;
                            mod_q_r <= ecc_cmd_i[2];
                            state   <= ecc_arith_pkg::ISSUE;
                        end
                        ecc_arith_pkg::CMD_SUB_P, ecc_arith_pkg::CMD_SUB_Q: begin
                            uc_idx  <= ecc_arith_pkg::UC_SUB;
                            mod_q_r <= ecc_cmd_i[2];
                            state   <= ecc_arith_pkg::ISSUE;
                        end
                        ecc_arith_pkg::CMD_EXP_P, ecc_arith_pkg::CMD_EXP_Q: begin
                            mod_q_r <= ecc_cmd_i[2];
                            state   <= ecc_arith_pkg::DIGIT;
                        end
                        default: ;
                    endcase
                end
                // Scalar MSB picks the ladder program
                ecc_arith_pkg::DIGIT: begin
                    uc_idx <= digit_i ? ecc_arith_pkg::UC_D1_A : ecc_arith_pkg::UC_D0_A;
                    state  <= ecc_arith_pkg::ISSUE;
                end
                // Addresses out, operands valid next cycle
                ecc_arith_pkg::ISSUE: state <= ecc_arith_pkg::READ;
                ecc_arith_pkg::READ:  state <= ecc_arith_pkg::EXEC;
                // Add words go straight on
                ecc_arith_pkg::EXEC: begin
                    if (!rom_word[ecc_arith_pkg::INSTR_MULT_BIT] || mult_done_i) begin
                        state <= ecc_arith_pkg::WRITE;
                    end
                end
                ecc_arith_pkg::WRITE: state <= ecc_arith_pkg::NEXT;
                ecc_arith_pkg::NEXT: begin
                    if (uc_idx == ecc_arith_pkg::UC_ADD || uc_idx == ecc_arith_pkg::UC_SUB) begin
                        state <= ecc_arith_pkg::IDLE;
                    end else if (uc_idx == ecc_arith_pkg::UC_D0_A ||
                                 uc_idx == ecc_arith_pkg::UC_D1_A) begin
                        // Second word of the digit program
                        uc_idx <= uc_idx + 3'd1;
                        state  <= ecc_arith_pkg::ISSUE;
                    end else if (digit_cnt == $bits(digit_cnt)'(ecc_arith_pkg::KEY_SIZE - 1)) begin
                        state <= ecc_arith_pkg::IDLE;
                    end else begin
                        digit_cnt <= digit_cnt + 1'b1;
                        state     <= ecc_arith_pkg::DIGIT;
                    end
                end
                default: state <= ecc_arith_pkg::IDLE;
            endcase
        end
    end

    // ------------------------------
    // Instruction issue
    // ------------------------------
    always_comb begin
        instr_o = rom_word;
        // Write enables only in WRITE
        instr_o[ecc_arith_pkg::INSTR_WEA_BIT] = rom_word[ecc_arith_pkg::INSTR_WEA_BIT] &&
                                                (state == ecc_arith_pkg::WRITE);
        instr_o[ecc_arith_pkg::INSTR_WEB_BIT] = rom_word[ecc_arith_pkg::INSTR_WEB_BIT] &&
                                                (state == ecc_arith_pkg::WRITE);
        // One-cycle FAU strobes in READ
        instr_o[ecc_arith_pkg::INSTR_MULT_BIT] = rom_word[ecc_arith_pkg::INSTR_MULT_BIT] &&
                                                 (state == ecc_arith_pkg::READ);
        instr_o[ecc_arith_pkg::INSTR_ADD_BIT]  = rom_word[ecc_arith_pkg::INSTR_ADD_BIT] &&
                                                 (state == ecc_arith_pkg::READ);
        instr_o[ecc_arith_pkg::INSTR_MODQ_BIT] = mod_q_r;
    end

    assign mod_q_o     = mod_q_r;
    assign req_digit_o = (state == ecc_arith_pkg::DIGIT);
    assign busy_o      = (state != ecc_arith_pkg::IDLE);

endmodule

// ==== src/ecc_ram_tdp_file.sv ====
// Dual-port operand memory
`timescale 1ns/1ps
module ecc_ram_tdp_file #(
    parameter int DATA_WIDTH = ecc_arith_pkg::REG_SIZE,
    parameter int ADDR_WIDTH = ecc_arith_pkg::ADDR_WIDTH
) (
    input  logic                  clk_i,
    input  logic                  reset_n,
    // Port A
    input  logic                  wea_i,
    input  logic [ADDR_WIDTH-1:0] addra_i,
    input  logic [DATA_WIDTH-1:0] dina_i,
    output logic [DATA_WIDTH-1:0] douta_o,
    // Port B
    input  logic                  web_i,
    input  logic [ADDR_WIDTH-1:0] addrb_i,
    input  logic [DATA_WIDTH-1:0] dinb_i,
    output logic [DATA_WIDTH-1:0] doutb_o
);

    logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

    // ------------------------------
    // Write side
    // ------------------------------
    // Both ports land in one process over the shared array
    always_ff @(posedge clk_i) begin
        if (wea_i) begin
            mem[addra_i] <= dina_i;
        end
        if (web_i) begin
            mem[addrb_i] <= dinb_i;
        end
    end

    // ------------------------------
    // Read side
    // ------------------------------
    // Registered outputs, old data on a same-port write
    always_ff @(posedge clk_i or negedge reset_n) begin
        if (!reset_n) begin
            douta_o <= '0;
            doutb_o <= '0;
        end else begin
            douta_o <= mem[addra_i];
            doutb_o <= mem[addrb_i];
        end
    end

endmodule

// ==== verilog.f ====
+incdir+sim
src/ecc_arith_pkg.sv
src/ecc_ram_tdp_file.sv
src/ecc_mod_mult.sv
src/ecc_fau.sv
src/ecc_pm_ctrl.sv
src/ecc_arith_unit.sv
sim/ecc_arith_unit_tb.sv
